//--- include/sd_load_config.svh
`ifndef SD_LOAD_CONFIG_SVH
`define SD_LOAD_CONFIG_SVH

//**********************************************************************
// sd load subsystem sizing
//**********************************************************************

// 16-bit words in one sd sector
`define SD_SECTOR_WORDS 256

// peer loaders sharing the sector reader, arbiter is built for 2
`define SD_NUM_LOADERS 2

// data word width on the read and ddr sides
`define SD_WORD_W 16

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the sd load testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal \
    --top-module tb_sd_load_top \
    -f sim.f \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi

//--- sim.f
+incdir+include
src/sd_load_pkg.sv
src/sd_rd_if.sv
src/sd_model_loader.sv
src/sd_load_arbiter.sv
src/sd_sector_reader.sv
src/sd_load_top.sv
verif/tb_sd_load_top.sv

//--- src/sd_load_arbiter.sv
`timescale 1ns/1ps
`include "sd_load_config.svh"

module sd_load_arbiter (
    input  logic    clk,
    input  logic    rst_n,
    sd_rd_if.arb_up up0,
    sd_rd_if.arb_up up1,
    sd_rd_if.loader down
);
    import sd_load_pkg::*;

    arb_state_t                 state;
    logic [`SD_NUM_LOADERS-1:0] pend;        // latched requests
    logic [`SD_NUM_LOADERS-1:0] own;         // one-hot owner of the reader
    logic [`SD_NUM_LOADERS-1:0] grant_vec;
    sec_addr_t                  pend_addr0;
    sec_addr_t                  pend_addr1;
    logic                       rr_last;     // loader granted last time
    logic                       grant_sel;
    logic                       can_grant;
    logic                       fwd;         // start still to be replayed
    logic                       busy_d;
    logic                       busy_fall;

    assign can_grant = (state != ARB_GRANTED) && (|pend);
    assign grant_sel = (&pend) ? ~rr_last : pend[1];  // alternate when both wait
    assign grant_vec = can_grant ? (grant_sel ? 2'b10 : 2'b01) : 2'b00;
    assign busy_fall = busy_d & ~down.rd_busy;

    // request capture
    always_ff @(posedge clk) begin
        if (up0.rd_start_en)
            pend_addr0 <= up0.rd_sec_addr;
        if (up1.rd_start_en)
            pend_addr1 <= up1.rd_sec_addr;
    end

    //******************************************************************
    // grant control
    //******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state            <= ARB_IDLE;
            pend             <= '0;
            own              <= '0;
            rr_last          <= 1'b1;       // loader 0 wins the first tie
            fwd              <= 1'b0;
            busy_d           <= 1'b0;
            down.rd_start_en <= 1'b0;
        end else begin
            busy_d           <= down.rd_busy;
            down.rd_start_en <= 1'b0;
            pend <= (pend & ~grant_vec) | {up1.rd_start_en, up0.rd_start_en};
            case (state)
                ARB_IDLE, ARB_RELEASE: begin
                    if (can_grant) begin
                        state   <= ARB_GRANTED;
                        own     <= grant_vec;
                        rr_last <= grant_sel;
                        fwd     <= 1'b1;
                    end else begin
                        state <= ARB_IDLE;
                    end
                end
                ARB_GRANTED: begin
                    if (fwd) begin
                        down.rd_start_en <= 1'b1;   // replay toward the reader
                        fwd              <= 1'b0;
                    end
                    if (busy_fall) begin
                        state <= ARB_RELEASE;
                        own   <= '0;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_GRANTED && fwd)
            down.rd_sec_addr <= own[1] ? pend_addr1 : pend_addr0;
    end

    // returns go to the owner only
    assign up0.rd_busy        = own[0] & down.rd_busy;
    assign up0.sd_rd_val_en   = own[0] & down.sd_rd_val_en;
    assign up0.sd_rd_val_data = down.sd_rd_val_data;
    assign up1.rd_busy        = own[1] & down.rd_busy;
    assign up1.sd_rd_val_en   = own[1] & down.sd_rd_val_en;
    assign up1.sd_rd_val_data = down.sd_rd_val_data;

    // a sector in flight always has exactly one owner
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        down.rd_busy |-> $onehot(own));

    // a new request never lands on one still waiting for its grant
    a_keep_pend0: assert property (@(posedge clk) disable iff (!rst_n)
        up0.rd_start_en |-> !pend[0]);

    a_keep_pend1: assert property (@(posedge clk) disable iff (!rst_n)
        up1.rd_start_en |-> !pend[1]);

endmodule

//--- src/sd_load_pkg.sv
`include "sd_load_config.svh"

package sd_load_pkg;

    typedef logic [31:0]                         sec_addr_t;  // sd sector address
    typedef logic [16:0]                         sec_cnt_t;   // sector count
    typedef logic [`SD_WORD_W-1:0]               sd_word_t;   // one data word
    typedef logic [$clog2(`SD_SECTOR_WORDS)-1:0] word_idx_t;  // word inside a sector

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT_SECTOR,
        LD_DONE
    } loader_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANTED,
        ARB_RELEASE
    } arb_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_DRAIN
    } reader_state_t;

endpackage

//--- src/sd_load_top.sv
`timescale 1ns/1ps

module sd_load_top (
    input  logic                   clk,
    input  logic                   rst_n,

    input  sd_load_pkg::sec_addr_t  sec_start_0,
    input  sd_load_pkg::sec_cnt_t   sec_num_0,
    input  sd_load_pkg::sec_addr_t  sec_start_1,
    input  sd_load_pkg::sec_cnt_t   sec_num_1,

    output logic                   card_rd_en,
    output sd_load_pkg::sec_addr_t  card_rd_sec,
    output sd_load_pkg::word_idx_t  card_rd_idx,
    input  sd_load_pkg::sd_word_t   card_rd_data,

    output logic                   ddr_wr_en_0,
    output logic                   ddr_wr_last_0,
    output sd_load_pkg::sd_word_t   ddr_wr_data_0,

    output logic                   ddr_wr_en_1,
    output logic                   ddr_wr_last_1,
    output sd_load_pkg::sd_word_t   ddr_wr_data_1
);

    //******************************************************************
    // sector-read channels
    //******************************************************************

    sd_rd_if rd_if_0 ();            // loader 0 to arbiter
    sd_rd_if rd_if_1 ();            // loader 1 to arbiter
    sd_rd_if rd_if_sh ();           // arbiter to shared reader

    sd_model_loader u_loader_0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .sec_start   (sec_start_0),
        .sec_num     (sec_num_0),
        .rd          (rd_if_0.loader),
        .ddr_wr_en   (ddr_wr_en_0),
        .ddr_wr_last (ddr_wr_last_0),
        .ddr_wr_data (ddr_wr_data_0)
    );

    sd_model_loader u_loader_1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .sec_start   (sec_start_1),
        .sec_num     (sec_num_1),
        .rd          (rd_if_1.loader),
        .ddr_wr_en   (ddr_wr_en_1),
        .ddr_wr_last (ddr_wr_last_1),
        .ddr_wr_data (ddr_wr_data_1)
    );

    sd_load_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .up0   (rd_if_0.arb_up),
        .up1   (rd_if_1.arb_up),
        .down  (rd_if_sh.loader)
    );

    sd_sector_reader u_reader (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd           (rd_if_sh.reader),
        .card_rd_en   (card_rd_en),
        .card_rd_sec  (card_rd_sec),
        .card_rd_idx  (card_rd_idx),
        .card_rd_data (card_rd_data)
    );

endmodule

//--- src/sd_model_loader.sv
`timescale 1ns/1ps
`include "sd_load_config.svh"

module sd_model_loader (
    input  logic                  clk,
    input  logic                  rst_n,
    input  sd_load_pkg::sec_addr_t sec_start,
    input  sd_load_pkg::sec_cnt_t  sec_num,
    sd_rd_if.loader               rd,
    output logic                  ddr_wr_en,
    output logic                  ddr_wr_last,
    output sd_load_pkg::sd_word_t  ddr_wr_data
);
    import sd_load_pkg::*;

    loader_state_t state;
    logic          busy_d0;
    logic          busy_d1;
    logic          busy_fall;       // one sector finished
    sec_cnt_t      sec_done;        // sectors finished so far
    sec_cnt_t      last_sec_idx;
    word_idx_t     word_cnt;        // word position inside the sector
    logic          last_sector;
    logic          end_of_sector;

    //******************************************************************
    // sector end detection
    //******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_d0 <= 1'b0;
            busy_d1 <= 1'b0;
        end else begin
            busy_d0 <= rd.rd_busy;
            busy_d1 <= busy_d0;
        end
    end

    assign busy_fall     = busy_d1 & ~busy_d0;
    assign last_sec_idx  = sec_num - sec_cnt_t'(1);
    assign last_sector   = (state == LD_WAIT_SECTOR) && (sec_done == last_sec_idx);
    assign end_of_sector = (word_cnt == word_idx_t'(`SD_SECTOR_WORDS - 1));

    //******************************************************************
    // sector request sequencing
    //******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= LD_IDLE;
            rd.rd_start_en <= 1'b0;
            sec_done       <= '0;
        end else begin
            rd.rd_start_en <= 1'b0;
            case (state)
                LD_IDLE: begin
                    if (sec_num == '0) begin
                        state <= LD_DONE;           // nothing to load
                    end else begin
                        rd.rd_start_en <= 1'b1;
                        state          <= LD_WAIT_SECTOR;
                    end
                end
                LD_WAIT_SECTOR: begin
                    if (busy_fall) begin
                        sec_done <= sec_done + sec_cnt_t'(1);
                        if (last_sector)
                            state <= LD_DONE;
                        else
                            rd.rd_start_en <= 1'b1; // next sector
                    end
                end
                LD_DONE: state <= LD_DONE;          // held until reset
                default: state <= LD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LD_IDLE)
            rd.rd_sec_addr <= sec_start;
        else if (busy_fall)
            rd.rd_sec_addr <= rd.rd_sec_addr + sec_addr_t'(1);
    end

    //******************************************************************
    // ddr write side
    //******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ddr_wr_en   <= 1'b0;
            ddr_wr_last <= 1'b0;
            word_cnt    <= '0;
        end else begin
            ddr_wr_en   <= rd.sd_rd_val_en;
            ddr_wr_last <= rd.sd_rd_val_en & last_sector & end_of_sector;
            if (rd.sd_rd_val_en)
                word_cnt <= end_of_sector ? '0 : word_cnt + word_idx_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rd.sd_rd_val_en)
            ddr_wr_data <= rd.sd_rd_val_data;
    end

    // last strobe lines up with the end of the final sector
    a_last_with_en: assert property (@(posedge clk) disable iff (!rst_n)
        ddr_wr_last |-> ddr_wr_en && !rd.rd_busy);

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rd.rd_start_en |-> !rd.rd_busy);

endmodule

//--- src/sd_rd_if.sv
`timescale 1ns/1ps

interface sd_rd_if;
    import sd_load_pkg::*;

    logic      rd_start_en;     // one-cycle start pulse
    sec_addr_t rd_sec_addr;     // sector, valid with the pulse
    logic      rd_busy;         // sector in flight
    logic      sd_rd_val_en;    // one pulse per word
    sd_word_t  sd_rd_val_data;

    modport loader (
        output rd_start_en, rd_sec_addr,
        input  rd_busy, sd_rd_val_en, sd_rd_val_data
    );

    modport arb_up (
        input  rd_start_en, rd_sec_addr,
        output rd_busy, sd_rd_val_en, sd_rd_val_data
    );

    modport reader (
        input  rd_start_en, rd_sec_addr,
        output rd_busy, sd_rd_val_en, sd_rd_val_data
    );

endinterface

//--- src/sd_sector_reader.sv
`timescale 1ns/1ps
`include "sd_load_config.svh"

module sd_sector_reader (
    input  logic                   clk,
    input  logic                   rst_n,
    sd_rd_if.reader                rd,
    output logic                   card_rd_en,
    output sd_load_pkg::sec_addr_t  card_rd_sec,
    output sd_load_pkg::word_idx_t  card_rd_idx,
    input  sd_load_pkg::sd_word_t   card_rd_data
);
    import sd_load_pkg::*;

    reader_state_t state;
    sec_addr_t     sec_q;           // sector being fetched
    word_idx_t     idx;
    logic          rd_en_d;         // card answers one cycle later
    logic          last_idx;

    assign last_idx = (idx == word_idx_t'(`SD_SECTOR_WORDS - 1));

    //******************************************************************
    // card fetch sequencing
    //******************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd.rd_start_en) begin
                        state <= RD_FETCH;
                        idx   <= '0;
                    end
                end
                RD_FETCH: begin
                    idx <= idx + word_idx_t'(1);
                    if (last_idx)
                        state <= RD_DRAIN;      // wait for the final answer
                end
                RD_DRAIN: state <= RD_IDLE;
                default:  state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && rd.rd_start_en)
            sec_q <= rd.rd_sec_addr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            rd_en_d <= 1'b0;
        else
            rd_en_d <= card_rd_en;
    end

    assign card_rd_en  = (state == RD_FETCH);
    assign card_rd_sec = sec_q;
    assign card_rd_idx = idx;

    // busy covers fetch plus the trailing answer
    assign rd.rd_busy        = (state != RD_IDLE);
    assign rd.sd_rd_val_en   = rd_en_d;
    assign rd.sd_rd_val_data = card_rd_data;

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rd.rd_start_en |-> !rd.rd_busy);

endmodule

//--- verif/tb_sd_load_top.sv
`timescale 1ns/1ps
`include "sd_load_config.svh"

module tb_sd_load_top;
    import sd_load_pkg::*;

    localparam int SECTOR_WORDS  = `SD_SECTOR_WORDS;
    localparam int TOTAL_SECTORS = 3 + 0 + 2 + 4;   // summed over both tests
    localparam int NUM_TESTS     = 2;
    localparam int QUIET_CYCLES  = 600;             // idle window after each load
    localparam int WATCH_CYCLES  = TOTAL_SECTORS * 300
                                 + NUM_TESTS * (QUIET_CYCLES + 20) + 500;

    logic      clk;
    logic      rst_n;
    sec_addr_t sec_start_0;
    sec_cnt_t  sec_num_0;
    sec_addr_t sec_start_1;
    sec_cnt_t  sec_num_1;
    logic      card_rd_en;
    sec_addr_t card_rd_sec;
    word_idx_t card_rd_idx;
    sd_word_t  card_rd_data;
    logic      ddr_wr_en_0;
    logic      ddr_wr_last_0;
    sd_word_t  ddr_wr_data_0;
    logic      ddr_wr_en_1;
    logic      ddr_wr_last_1;
    sd_word_t  ddr_wr_data_1;

    integer      seed;
    int          fail_cnt;
    sec_addr_t   start_q [2];
    int          num_q [2];
    int          wr_cnt [2];       // ddr writes seen per stream
    logic        done [2];
    int          rd_cnt [2];       // sectors fetched per loader
    logic [15:0] seen [2];         // sector offsets already fetched
    int          exp_idx;
    sec_addr_t   cur_sec;
    int          prev_owner;
    int          since_rst;
    logic        req_en;           // card request from the previous cycle
    sec_addr_t   req_sec;
    word_idx_t   req_idx;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    sd_load_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .sec_start_0   (sec_start_0),
        .sec_num_0     (sec_num_0),
        .sec_start_1   (sec_start_1),
        .sec_num_1     (sec_num_1),
        .card_rd_en    (card_rd_en),
        .card_rd_sec   (card_rd_sec),
        .card_rd_idx   (card_rd_idx),
        .card_rd_data  (card_rd_data),
        .ddr_wr_en_0   (ddr_wr_en_0),
        .ddr_wr_last_0 (ddr_wr_last_0),
        .ddr_wr_data_0 (ddr_wr_data_0),
        .ddr_wr_en_1   (ddr_wr_en_1),
        .ddr_wr_last_1 (ddr_wr_last_1),
        .ddr_wr_data_1 (ddr_wr_data_1)
    );

    //**********************************************************************
    // card contents and expected streams
    //**********************************************************************

    function automatic sd_word_t card_word(input sec_addr_t sec, input int idx);
        logic [31:0] sum;
        sum = sec * 32'd37 + 32'(idx);
        return sum[15:0] ^ 16'h5a5a;
    endfunction

    // n-th word of loader k, counted over its whole sector range
    function automatic sd_word_t expected_word(input int k, input int n);
        return card_word(start_q[k] + sec_addr_t'(n / SECTOR_WORDS), n % SECTOR_WORDS);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_cnt = fail_cnt + 1;
            $display("tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // card answers one cycle after the request
    always @(negedge clk) begin
        if (req_en)
            card_rd_data <= card_word(req_sec, int'(req_idx));
        req_en  <= card_rd_en;
        req_sec <= card_rd_sec;
        req_idx <= card_rd_idx;
    end

    //**********************************************************************
    // stream and reader monitors
    //**********************************************************************

    task automatic compare_stream(input int k, input logic en, input logic last,
                                  input sd_word_t data);
        int total;
        total = num_q[k] * SECTOR_WORDS;
        if (en) begin
            if (wr_cnt[k] >= total)
                check_val($sformatf("ddr_wr_en_%0d", k), 32'd1, 32'd0);
            check_val($sformatf("ddr_wr_data_%0d", k), 32'(data),
                      32'(expected_word(k, wr_cnt[k])));
            check_val($sformatf("ddr_wr_last_%0d", k), 32'(last),
                      32'(wr_cnt[k] == total - 1));
            wr_cnt[k] = wr_cnt[k] + 1;
            if (wr_cnt[k] == total)
                done[k] = 1'b1;
        end else begin
            check_val($sformatf("ddr_wr_last_%0d", k), 32'(last), 32'd0);
        end
    endtask

    task automatic check_reader();
        int   owner;
        int   off;
        logic both_left;
        if (card_rd_en) begin
            if (exp_idx == 0) begin                 // first word of a new sector
                owner = 0;
                if (sec_addr_t'(card_rd_sec - start_q[1]) < sec_addr_t'(num_q[1]))
                    owner = 1;
                check_val("card_rd_sec offset in range",
                          32'((card_rd_sec - start_q[owner]) < sec_addr_t'(num_q[owner])),
                          32'd1);
                off       = int'(card_rd_sec - start_q[owner]);
                both_left = (rd_cnt[0] < num_q[0]) && (rd_cnt[1] < num_q[1]);
                check_val("card_rd_sec already read", 32'(seen[owner][off]), 32'd0);
                if (both_left && prev_owner >= 0)
                    check_val("card_rd_sec owner", 32'(owner), 32'(1 - prev_owner));
                seen[owner][off] = 1'b1;
                rd_cnt[owner]    = rd_cnt[owner] + 1;
                prev_owner       = owner;
                cur_sec          = card_rd_sec;
            end
            check_val("card_rd_sec", card_rd_sec, cur_sec);
            check_val("card_rd_idx", 32'(card_rd_idx), 32'(exp_idx));
            exp_idx = (exp_idx + 1) % SECTOR_WORDS;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n || since_rst < 2) begin          // quiet in and just after reset
            check_val("card_rd_en", 32'(card_rd_en), 32'd0);
            check_val("ddr_wr_en_0", 32'(ddr_wr_en_0), 32'd0);
            check_val("ddr_wr_en_1", 32'(ddr_wr_en_1), 32'd0);
            check_val("ddr_wr_last_0", 32'(ddr_wr_last_0), 32'd0);
            check_val("ddr_wr_last_1", 32'(ddr_wr_last_1), 32'd0);
        end
        if (!rst_n)
            since_rst = 0;
        else if (since_rst < 2)
            since_rst = since_rst + 1;
        if (rst_n) begin
            compare_stream(0, ddr_wr_en_0, ddr_wr_last_0, ddr_wr_data_0);
            compare_stream(1, ddr_wr_en_1, ddr_wr_last_1, ddr_wr_data_1);
            check_reader();
        end
    end

    //**********************************************************************
    // test sequence
    //**********************************************************************

    task automatic run_load(input sec_cnt_t n0, input sec_cnt_t n1);
        @(negedge clk);
        rst_n      = 1'b0;
        start_q[0] = sec_addr_t'($random(seed)) & 32'h00ff_fff0;
        start_q[1] = (sec_addr_t'($random(seed)) & 32'h00ff_fff0) | 32'h0100_0000;
        num_q[0]   = int'(n0);
        num_q[1]   = int'(n1);
        sec_start_0 = start_q[0];
        sec_start_1 = start_q[1];
        sec_num_0   = n0;
        sec_num_1   = n1;
        for (int k = 0; k < 2; k++) begin
            wr_cnt[k] = 0;
            rd_cnt[k] = 0;
            seen[k]   = '0;
            done[k]   = (num_q[k] == 0);
        end
        exp_idx    = 0;
        prev_owner = -1;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        wait (done[0] && done[1]);
        repeat (QUIET_CYCLES) @(negedge clk);       // no writes after the load
        check_val("ddr_wr_en_0 count", 32'(wr_cnt[0]), 32'(num_q[0] * SECTOR_WORDS));
        check_val("ddr_wr_en_1 count", 32'(wr_cnt[1]), 32'(num_q[1] * SECTOR_WORDS));
        check_val("card_rd_sec count 0", 32'(rd_cnt[0]), 32'(num_q[0]));
        check_val("card_rd_sec count 1", 32'(rd_cnt[1]), 32'(num_q[1]));
        check_val("card_rd_idx at sector end", 32'(exp_idx), 32'd0);
    endtask

    initial begin
        seed         = 32'h94f6;
        fail_cnt     = 0;
        rst_n        = 1'b0;
        sec_start_0  = '0;
        sec_num_0    = '0;
        sec_start_1  = '0;
        sec_num_1    = '0;
        card_rd_data = '0;
        req_en       = 1'b0;
        req_sec      = '0;
        req_idx      = '0;
        since_rst    = 0;
        exp_idx      = 0;
        cur_sec      = '0;
        prev_owner   = -1;
        for (int k = 0; k < 2; k++) begin
            start_q[k] = '0;
            num_q[k]   = 0;
            wr_cnt[k]  = 0;
            rd_cnt[k]  = 0;
            seen[k]    = '0;
            done[k]    = 1'b0;
        end
        run_load(17'd3, 17'd0);     // loader 0 alone
        run_load(17'd2, 17'd4);     // both loaders share the reader
        if (fail_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: loads did not finish within %0d cycles", WATCH_CYCLES);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule
